/* x68k_glue.f */
+incdir+source
source/x68k_glue_pkg.sv
source/core_ctrl.sv
source/ce_gen.sv
source/act_led.sv
source/mt32_osd.sv
source/x68k_glue.sv
sim/x68k_glue_asserts.sv
sim/tb_checker.sv
sim/tb_x68k_glue.sv

/* sim/tb_x68k_glue.sv */
// Testbench top for the X68000 glue with stimulus, acknowledge model and final report
`timescale 1ns/1ps

module tb_x68k_glue;
	import x68k_glue_pkg::*;

	localparam int LED_HOLD   = 40;
	localparam int LCD_HOLD   = 60;
	// Tests need at most about 1000 cycles
	localparam int MAX_CYCLES = 6000;

	logic       clk_sys, arst_n;
	logic       user_btn, menu_reset, host_reset, sys_rstn;
	logic       ioctl_download, ioctl_wr, ioctl_wait, ldr_ack;
	ldr_bus_t   ldr;
	logic       turbo_req, snd_slow;
	ce_bus_t    ce;
	logic       disk_act, led_disk;
	logic       mt32_newmode, lcd_update, lcd_en, lcd_pix;
	mt32_stat_t mt32;
	info_sel_e  info_sel;
	rgb_t       pixel, video_out;
	logic       info_req;
	logic [3:0] info_disp;

	int          err_cnt;
	int          cyc;
	logic [31:0] stim_lfsr;
	logic [31:0] ack_lfsr;

	x68k_glue #(.LED_HOLD(LED_HOLD), .LCD_HOLD(LCD_HOLD)) uut (.*);

	tb_checker #(.LED_HOLD(LED_HOLD), .LCD_HOLD(LCD_HOLD)) chk (.*);

	bind core_ctrl x68k_glue_asserts u_asserts (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.user_btn       (user_btn),
		.menu_reset     (menu_reset),
		.host_reset     (host_reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ldr_ack        (ldr_ack),
		.ce_run         (ce_run),
		.ldr            (ldr)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	task automatic take_bits(inout logic [31:0] state, input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v     = {v[30:0], state[0]};
			state = lfsr_step(state);
		end
	endtask

	// Inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic idle(input int n);
		repeat (n) next_cycle();
	endtask

	task automatic host_write();
		ioctl_wr = 1'b1;
		next_cycle();
		ioctl_wr = 1'b0;
	endtask

	task automatic drive_pixels(input int n);
		logic [31:0] r;
		repeat (n) begin
			take_bits(stim_lfsr, 24, r);
			pixel = r[23:0];
			take_bits(stim_lfsr, 1, r);
			lcd_pix = r[0];
			// Overlay enabled three times out of four
			take_bits(stim_lfsr, 2, r);
			lcd_en = (r[1:0] != 2'd0);
			next_cycle();
		end
	endtask

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cyc++;
		if (cyc >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Core side of the loader, acknowledges 2 to 5 cycles after a request
	initial begin
		logic [31:0] d;
		ldr_ack  = 1'b0;
		ack_lfsr = 32'h61809419;
		forever begin
			next_cycle();
			if (ldr.wr && !ldr_ack) begin
				take_bits(ack_lfsr, 2, d);
				idle(2 + d[1:0]);
				ldr_ack = 1'b1;
				while (ldr.wr)
					next_cycle();
				ldr_ack = 1'b0;
			end
		end
	end

	initial begin
		logic [31:0] r;
		int          afail;
		cyc = 0;
		stim_lfsr = 32'h61809419;
		arst_n = 1'b0;
		{user_btn, host_reset, ioctl_download, ioctl_wr} = '0;
		// Menu holds reset at startup
		menu_reset = 1'b1;
		{turbo_req, snd_slow, disk_act} = '0;
		{mt32_newmode, lcd_update, lcd_en, lcd_pix} = '0;
		mt32     = '0;
		info_sel = INFO_OFF;
		pixel    = '0;
		repeat (3) @(posedge clk_sys);
		#1 arst_n = 1'b1;

		// Reset sequence: menu release, then first download
		idle(5);
		menu_reset = 1'b0;
		idle(5);
		ioctl_download = 1'b1;
		while (!sys_rstn)
			next_cycle();
		idle(10);
		user_btn = 1'b1;
		next_cycle();
		user_btn = 1'b0;
		while (!sys_rstn)
			next_cycle();

		// Clock enables in every mode
		idle(60);
		snd_slow = 1'b1;
		idle(60);
		turbo_req = 1'b1;
		idle(60);
		snd_slow = 1'b0;
		idle(40);
		turbo_req = 1'b0;
		idle(40);
		host_reset = 1'b1;
		idle(5);
		host_reset = 1'b0;
		while (!sys_rstn)
			next_cycle();
		idle(30);

		// Loader writes with random gaps
		for (int i = 0; i < 8; i++) begin
			while (ioctl_wait)
				next_cycle();
			host_write();
			// Write while stalled, must be dropped
			if (i == 3)
				host_write();
			take_bits(stim_lfsr, 3, r);
			idle(r[2:0]);
		end
		while (ioctl_wait)
			next_cycle();
		ioctl_download = 1'b0;
		idle(3);
		host_write();
		idle(2);
		host_write();
		idle(5);

		// Disk LED
		for (int i = 0; i < 10; i++) begin
			disk_act = 1'b1;
			next_cycle();
			disk_act = 1'b0;
			take_bits(stim_lfsr, 4, r);
			idle(r[3:0]);
		end
		disk_act = 1'b1;
		idle(5);
		disk_act = 1'b0;
		idle(50);

		// MT32 info codes and popup requests
		info_sel = INFO_ON_CHANGE;
		for (int i = 0; i < 20; i++) begin
			take_bits(stim_lfsr, 2, r);
			case (r[1:0])
				2'd0: mt32.mode = 8'hA2;
				2'd1: mt32.mode = 8'hA1;
				default: begin
					take_bits(stim_lfsr, 8, r);
					mt32.mode = r[7:0];
				end
			endcase
			take_bits(stim_lfsr, 2, r);
			mt32.rom = r[1:0];
			take_bits(stim_lfsr, 3, r);
			mt32.sf = r[2:0];
			if (i % 5 == 0)
				mt32_newmode = ~mt32_newmode;
			idle(2);
		end
		idle(4);
		info_sel = INFO_OFF;
		mt32_newmode = ~mt32_newmode;
		idle(4);
		mt32_newmode = ~mt32_newmode;
		idle(4);

		// LCD overlay for each selector
		drive_pixels(12);
		info_sel = INFO_ON_CHANGE;
		drive_pixels(12);
		info_sel = INFO_LCD_ON;
		drive_pixels(12);
		info_sel = INFO_LCD_AUTO;
		drive_pixels(10);
		lcd_update = ~lcd_update;
		drive_pixels(80);
		lcd_update = ~lcd_update;
		drive_pixels(20);
		lcd_update = ~lcd_update;
		drive_pixels(70);
		idle(3);

		afail = uut.u_core_ctrl.u_asserts.fail_cnt;
		$display("Run complete: %0d check errors, %0d assertion failures", err_cnt, afail);
		if (err_cnt == 0 && afail == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* sim/tb_checker.sv */
// Checker that models the glue rules cycle by cycle and compares the DUT outputs
`timescale 1ns/1ps
`include "x68k_glue_defs.svh"

module tb_checker #(
	parameter int LED_HOLD = 40,
	parameter int LCD_HOLD = 60
) (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      user_btn,
	input  logic                      menu_reset,
	input  logic                      host_reset,
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	input  logic                      ldr_ack,
	input  logic                      turbo_req,
	input  logic                      snd_slow,
	input  logic                      disk_act,
	input  logic                      mt32_newmode,
	input  x68k_glue_pkg::mt32_stat_t mt32,
	input  x68k_glue_pkg::info_sel_e  info_sel,
	input  logic                      lcd_update,
	input  logic                      lcd_en,
	input  logic                      lcd_pix,
	input  x68k_glue_pkg::rgb_t       pixel,
	input  logic                      sys_rstn,
	input  logic                      ioctl_wait,
	input  x68k_glue_pkg::ldr_bus_t   ldr,
	input  x68k_glue_pkg::ce_bus_t    ce,
	input  logic                      led_disk,
	input  logic                      info_req,
	input  logic [3:0]                info_disp,
	input  x68k_glue_pkg::rgb_t       video_out,
	output int                        err_cnt
);
	import x68k_glue_pkg::*;

	int cyc;
	// Reset model, two-stage history
	logic dl_seen, menu_seen, dl_prev, menu_prev;
	logic seen_d1, seen_d2, or_d1, or_d2;
	// Enable spacing
	int   last[6];
	bit   have[6];
	logic rstn_prev, turbo_prev, slow_prev;
	int   mpu_settle, snd_settle;
	// Loader state model
	ldr_bus_t exp_ldr;
	logic     ack_prev, dl_prev_l;
	// LED, MT32 and video
	int       last_act, last_tgl;
	logic     act_seen, tgl_seen, upd_prev, lcd_on_m;
	logic     nm_d1, nm_d2, nm_d3;
	info_sel_e sel_d1;
	logic [3:0] exp_info;
	rgb_t     exp_vid;
	logic     info_valid, vid_valid;

	initial err_cnt = 0;

	////////////////////////////////////////
	// Reference functions
	////////////////////////////////////////

	// Pulse spacing of each enable, index 0 is sys_ce
	function automatic int ce_period(input int idx, input logic turbo, input logic slow);
		case (idx)
			0: return `X68K_DIV_SYS;
			1, 2: return turbo ? 2 : `X68K_DIV_SYS;
			3: return slow ? `X68K_DIV_SND_SLOW : `X68K_DIV_SND;
			4: return `X68K_DIV_SND_SLOW;
			default: return `X68K_DIV_OPM;
		endcase
	endfunction

	function automatic string ce_name(input int idx);
		case (idx)
			0: return "sys_ce";
			1: return "mpu_cep";
			2: return "mpu_cen";
			3: return "snd_ce";
			4: return "opm_ce[0]";
			default: return "opm_ce[1]";
		endcase
	endfunction

	// Menu code: SoundFont 1..8, ROM 9..11, else unknown
	function automatic logic [3:0] info_code(input mt32_stat_t s);
		if (s.mode == 8'hA2)
			return 4'd1 + {1'b0, s.sf};
		if (s.mode == 8'hA1 && s.rom <= 2'd2)
			return 4'd9 + {2'b00, s.rom};
		return 4'd12;
	endfunction

	function automatic rgb_t overlay_px(input rgb_t p, input logic on, input logic pix);
		rgb_t o;
		if (!on)
			return p;
		o.r = {pix, pix, p.r[7:2]};
		o.g = {pix, pix, p.g[7:2]};
		o.b = {pix, pix, p.b[7:2]};
		return o;
	endfunction

	task automatic report(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("[FAIL] %s: expected %0h, actual %0h at cycle %0d", name, exp, act, cyc);
		err_cnt++;
	endtask

	////////////////////////////////////////
	// Per-cycle checks
	////////////////////////////////////////

	task automatic reset_sequence();
		logic exp;
		exp = seen_d2 & ~or_d2;
		if (sys_rstn !== exp)
			report("sys_rstn", exp, sys_rstn);
		or_d2 = or_d1;
		or_d1 = user_btn | menu_reset | host_reset;
		if (ioctl_download && !dl_prev)
			dl_seen = 1'b1;
		if (!menu_reset && menu_prev)
			menu_seen = 1'b1;
		dl_prev   = ioctl_download;
		menu_prev = menu_reset;
		seen_d2   = seen_d1;
		seen_d1   = dl_seen & menu_seen;
	endtask

	task automatic enable_pulses();
		logic [5:0] p;
		p = {ce.opm_ce[1], ce.opm_ce[0], ce.snd_ce, ce.mpu_cen, ce.mpu_cep, ce.sys_ce};
		if (!sys_rstn && !rstn_prev && ce !== '0)
			report("enables in reset", 0, ce);
		if (!sys_rstn)
			have = '{default: 0};
		// Counters start from zero when the core leaves reset
		if (sys_rstn && !rstn_prev) begin
			for (int i = 0; i < 6; i++)
				last[i] = cyc;
		end
		// Mode switches make one irregular gap
		if (turbo_req !== turbo_prev)
			mpu_settle = 8;
		if (snd_slow !== slow_prev)
			snd_settle = 3;
		if (mpu_settle > 0) begin
			mpu_settle--;
			have[1] = 0;
			have[2] = 0;
			last[1] = cyc;
			last[2] = cyc;
		end
		if (snd_settle > 0) begin
			snd_settle--;
			have[3] = 0;
			last[3] = cyc;
		end
		if (sys_rstn && mpu_settle == 0) begin
			if (!turbo_req && ce.mpu_cep !== ce.sys_ce)
				report("mpu_cep with sys_ce", ce.sys_ce, ce.mpu_cep);
			if (!turbo_req && ce.mpu_cen && have[1] && cyc - last[1] != 2)
				report("mpu_cen after mpu_cep", 2, cyc - last[1]);
			if (turbo_req && ce.mpu_cep && ce.mpu_cen)
				report("turbo cep/cen overlap", 0, 1);
		end
		for (int i = 0; i < 6; i++) begin
			if (p[i]) begin
				if (have[i] && cyc - last[i] != ce_period(i, turbo_req, snd_slow))
					report({ce_name(i), " period"}, ce_period(i, turbo_req, snd_slow),
						cyc - last[i]);
				last[i] = cyc;
				have[i] = 1;
			end else if (sys_rstn && cyc - last[i] > ce_period(i, 1'b0, 1'b1)) begin
				// Longest legal gap is the period of the slower mode
				$display("Missing pulse: no %s for %0d cycles at cycle %0d",
					ce_name(i), cyc - last[i], cyc);
				err_cnt++;
				last[i] = cyc;
				have[i] = 0;
			end
		end
		rstn_prev  = sys_rstn;
		turbo_prev = turbo_req;
		slow_prev  = snd_slow;
	endtask

	task automatic loader_handshake();
		logic     ack_rise, dl_rise, dl_fall, accepted;
		ldr_bus_t n;
		if (ioctl_wait !== exp_ldr.wr)
			report("ioctl_wait", exp_ldr.wr, ioctl_wait);
		if (ldr !== exp_ldr)
			report("loader bus aen/wr/done", exp_ldr, ldr);
		ack_rise = ldr_ack && !ack_prev;
		dl_rise  = ioctl_download && !dl_prev_l;
		dl_fall  = !ioctl_download && dl_prev_l;
		// Only an idle loader takes a write, end of download wins
		accepted = ioctl_wr && exp_ldr.aen && !exp_ldr.wr && !dl_fall;
		n.wr     = accepted || (exp_ldr.wr && !ack_rise);
		n.done   = exp_ldr.done || (exp_ldr.aen && !exp_ldr.wr && dl_fall) ||
			(exp_ldr.wr && ack_rise && !ioctl_download);
		n.aen    = (!exp_ldr.aen && !exp_ldr.done && dl_rise) || (exp_ldr.aen && !n.done);
		exp_ldr   = n;
		ack_prev  = ldr_ack;
		dl_prev_l = ioctl_download;
	endtask

	task automatic led_stretch();
		logic exp;
		exp = act_seen && (cyc - last_act) <= LED_HOLD;
		if (led_disk !== exp)
			report("led_disk", exp, led_disk);
		if (disk_act) begin
			act_seen = 1'b1;
			last_act = cyc;
		end
	endtask

	task automatic mt32_status();
		logic exp_req;
		if (info_valid && info_disp !== exp_info)
			report("info_disp", exp_info, info_disp);
		exp_info   = info_code(mt32);
		info_valid = 1'b1;
		// Toggle seen two samples back, popup only on change
		exp_req = (nm_d2 ^ nm_d3) && (sel_d1 == INFO_ON_CHANGE);
		if (info_req !== exp_req)
			report("info_req", exp_req, info_req);
		nm_d3  = nm_d2;
		nm_d2  = nm_d1;
		nm_d1  = mt32_newmode;
		sel_d1 = info_sel;
	endtask

	task automatic lcd_overlay();
		logic tgl;
		if (vid_valid && video_out !== exp_vid)
			report("video_out", exp_vid, video_out);
		exp_vid   = overlay_px(pixel, lcd_on_m && lcd_en, lcd_pix);
		vid_valid = 1'b1;
		tgl = lcd_update ^ upd_prev;
		upd_prev = lcd_update;
		if (info_sel == INFO_LCD_AUTO && tgl) begin
			tgl_seen = 1'b1;
			last_tgl = cyc;
		end
		case (info_sel)
			INFO_LCD_ON: lcd_on_m = 1'b1;
			INFO_LCD_AUTO: lcd_on_m = tgl_seen && (cyc - last_tgl) < LCD_HOLD;
			default: lcd_on_m = 1'b0;
		endcase
	endtask

	always @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cyc = 0;
			{dl_seen, menu_seen, dl_prev, menu_prev} = '0;
			{seen_d1, seen_d2, or_d1, or_d2} = '0;
			have = '{default: 0};
			{rstn_prev, turbo_prev, slow_prev} = '0;
			mpu_settle = 0;
			snd_settle = 0;
			exp_ldr = '0;
			{ack_prev, dl_prev_l} = '0;
			{act_seen, tgl_seen, upd_prev, lcd_on_m} = '0;
			{nm_d1, nm_d2, nm_d3} = '0;
			sel_d1 = INFO_OFF;
			info_valid = 1'b0;
			vid_valid  = 1'b0;
		end else begin
			cyc++;
			reset_sequence();
			enable_pulses();
			loader_handshake();
			led_stretch();
			mt32_status();
			lcd_overlay();
		end
	end

endmodule

/* sim/x68k_glue_asserts.sv */
// Concurrent assertions on the loader handshake and the enable stop of core_ctrl
`timescale 1ns/1ps

module x68k_glue_asserts (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  logic                    user_btn,
	input  logic                    menu_reset,
	input  logic                    host_reset,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic                    ldr_ack,
	input  logic                    ce_run,
	input  x68k_glue_pkg::ldr_bus_t ldr
);
	import x68k_glue_pkg::*;

	// Failed assertions so far
	int fail_cnt;

	initial fail_cnt = 0;

	// A write request only follows a host write
	a_wr_from_host: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(ldr.wr) |-> $past(ioctl_wr))
	else begin
		$error("ldr.wr rose without a host write");
		fail_cnt++;
	end

	// End of download in idle gives done on the next cycle
	a_dl_end_done: assert property (@(posedge clk_sys) disable iff (!arst_n)
		($fell(ioctl_download) && ldr.aen && !ldr.wr) |=> ldr.done)
	else begin
		$error("ldr.done did not follow the end of the download");
		fail_cnt++;
	end

	// Done is sticky
	a_done_sticky: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ldr.done |=> ldr.done)
	else begin
		$error("ldr.done fell after it was set");
		fail_cnt++;
	end

	// An acknowledge edge ends the write on the next cycle
	a_ack_ends_wr: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(ldr.wr && $rose(ldr_ack)) |=> !ldr.wr)
	else begin
		$error("ldr.wr stayed high after the acknowledge edge");
		fail_cnt++;
	end

	// Any reset source stops the enables two cycles later
	a_rst_stops_ce: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(user_btn || menu_reset || host_reset) |-> ##2 !ce_run)
	else begin
		$error("ce_run still high two cycles after a reset input");
		fail_cnt++;
	end

endmodule

/* source/x68k_glue.sv */
// X68000 glue top connecting core control, clock enables, disk LED and MT32 status
`timescale 1ns/1ps
`include "x68k_glue_defs.svh"

module x68k_glue #(
	parameter int LED_HOLD = `X68K_LED_HOLD,
	parameter int LCD_HOLD = `X68K_LCD_HOLD
) (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	// Reset sources
	input  logic                      user_btn,
	input  logic                      menu_reset,
	input  logic                      host_reset,
	output logic                      sys_rstn,
	// Host download and loader
	input  logic                      ioctl_download,
	input  logic                      ioctl_wr,
	output logic                      ioctl_wait,
	input  logic                      ldr_ack,
	output x68k_glue_pkg::ldr_bus_t   ldr,
	// Clock enables
	input  logic                      turbo_req,
	input  logic                      snd_slow,
	output x68k_glue_pkg::ce_bus_t    ce,
	// Disk LED
	input  logic                      disk_act,
	output logic                      led_disk,
	// MT32-pi status and video
	input  logic                      mt32_newmode,
	input  x68k_glue_pkg::mt32_stat_t mt32,
	input  x68k_glue_pkg::info_sel_e  info_sel,
	input  logic                      lcd_update,
	input  logic                      lcd_en,
	input  logic                      lcd_pix,
	input  x68k_glue_pkg::rgb_t       pixel,
	output logic                      info_req,
	output logic [3:0]                info_disp,
	output x68k_glue_pkg::rgb_t       video_out
);
	// Enables run only while the core is out of reset
	logic ce_run;

	////////////////////////////////////////
	// Control
	////////////////////////////////////////

	core_ctrl u_core_ctrl (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.user_btn       (user_btn),
		.menu_reset     (menu_reset),
		.host_reset     (host_reset),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ldr_ack        (ldr_ack),
		.sys_rstn       (sys_rstn),
		.ce_run         (ce_run),
		.ioctl_wait     (ioctl_wait),
		.ldr            (ldr)
	);

	////////////////////////////////////////
	// Datapath
	////////////////////////////////////////

	ce_gen u_ce_gen (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.ce_run    (ce_run),
		.turbo_req (turbo_req),
		.snd_slow  (snd_slow),
		.ce        (ce)
	);

	act_led #(
		.HOLD_CYCLES (LED_HOLD)
	) u_act_led (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.act     (disk_act),
		.led     (led_disk)
	);

	mt32_osd #(
		.LCD_HOLD (LCD_HOLD)
	) u_mt32_osd (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.mt32_newmode (mt32_newmode),
		.mt32         (mt32),
		.info_sel     (info_sel),
		.lcd_update   (lcd_update),
		.lcd_en       (lcd_en),
		.lcd_pix      (lcd_pix),
		.pixel        (pixel),
		.info_req     (info_req),
		.info_disp    (info_disp),
		.video_out    (video_out)
	);

endmodule

/* source/mt32_osd.sv */
// MT32-pi status block with info code, info request, LCD timer and pixel overlay
`timescale 1ns/1ps
`include "x68k_glue_defs.svh"

module mt32_osd #(
	parameter int LCD_HOLD = `X68K_LCD_HOLD
) (
	input  logic                      clk_sys,
	input  logic                      arst_n,
	input  logic                      mt32_newmode,
	input  x68k_glue_pkg::mt32_stat_t mt32,
	input  x68k_glue_pkg::info_sel_e  info_sel,
	input  logic                      lcd_update,
	input  logic                      lcd_en,
	input  logic                      lcd_pix,
	input  x68k_glue_pkg::rgb_t       pixel,
	output logic                      info_req,
	output logic [3:0]                info_disp,
	output x68k_glue_pkg::rgb_t       video_out
);
	import x68k_glue_pkg::*;

	localparam int TO_W = $clog2(LCD_HOLD + 1);

	// Newmode passes a sample stage before its edge register
	logic newmode_s;
	logic newmode_q;
	logic update_q;
	logic update_tgl;

	// LCD timeout and on flag
	logic [TO_W-1:0] lcd_to;
	logic            lcd_on;

	// Top two bits from the LCD, rest shifted down
	function automatic logic [7:0] lcd_mix(input logic [7:0] ch, input logic pix);
		return {{2{pix}}, ch[7:2]};
	endfunction

	assign update_tgl = update_q ^ lcd_update;

	////////////////////////////////////////
	// Control registers
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			newmode_s <= 1'b0;
			newmode_q <= 1'b0;
			update_q  <= 1'b0;
			info_req  <= 1'b0;
			lcd_to    <= '0;
			lcd_on    <= 1'b0;
		end else begin
			newmode_s <= mt32_newmode;
			newmode_q <= newmode_s;
			update_q  <= lcd_update;
			// Popup request only when the menu asks for it
			info_req  <= (newmode_s ^ newmode_q) && (info_sel == INFO_ON_CHANGE);

			if (lcd_to != '0)
				lcd_to <= lcd_to - 1'b1;

			case (info_sel)
				INFO_LCD_ON: lcd_on <= 1'b1;
				INFO_LCD_AUTO: begin
					// Each update restarts the timeout
					if (update_tgl)
						lcd_to <= TO_W'(LCD_HOLD);
					lcd_on <= update_tgl || (lcd_to > TO_W'(1));
				end
				default: lcd_on <= 1'b0;
			endcase
		end
	end

	////////////////////////////////////////
	// Info code and video overlay
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (mt32.mode == `X68K_MT32_MODE_FLUID)
			info_disp <= `X68K_INFO_SF_BASE + {1'b0, mt32.sf};
		else if (mt32.mode == `X68K_MT32_MODE_MUNT && mt32.rom != 2'd3)
			info_disp <= `X68K_INFO_ROM_BASE + {2'b00, mt32.rom};
		else
			info_disp <= `X68K_INFO_UNKNOWN;

		if (lcd_on && lcd_en) begin
			video_out.r <= lcd_mix(pixel.r, lcd_pix);
			video_out.g <= lcd_mix(pixel.g, lcd_pix);
			video_out.b <= lcd_mix(pixel.b, lcd_pix);
		end else begin
			video_out <= pixel;
		end
	end

endmodule

/* source/act_led.sv */
// Activity LED stretcher, holds the LED on for a while after each pulse
`timescale 1ns/1ps
`include "x68k_glue_defs.svh"

module act_led #(
	parameter int HOLD_CYCLES = `X68K_LED_HOLD
) (
	input  logic clk_sys,
	input  logic arst_n,
	input  logic act,
	output logic led
);
	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	// Cycles left before the LED goes dark
	logic [CNT_W-1:0] hold_cnt;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hold_cnt <= '0;
		end else if (act) begin
			// Retrigger, activity keeps the LED lit
			hold_cnt <= CNT_W'(HOLD_CYCLES);
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Lit while the hold runs
	assign led = (hold_cnt != '0);

endmodule

/* source/ce_gen.sv */
// Clock-enable generator for system, CPU (normal or turbo), sound and OPM
`timescale 1ns/1ps
`include "x68k_glue_defs.svh"

module ce_gen (
	input  logic                   clk_sys,
	input  logic                   arst_n,
	input  logic                   ce_run,
	input  logic                   turbo_req,
	input  logic                   snd_slow,
	output x68k_glue_pkg::ce_bus_t ce
);
	localparam int SYS_W  = $clog2(`X68K_DIV_SYS);
	localparam int SND_W  = $clog2(`X68K_DIV_SND);
	localparam int SND2_W = $clog2(`X68K_DIV_SND_SLOW);
	localparam int OPM_W  = $clog2(`X68K_DIV_OPM);

	// Terminal counts
	localparam logic [SYS_W-1:0]  SYS_LAST  = SYS_W'(`X68K_DIV_SYS - 1);
	localparam logic [SND_W-1:0]  SND_LAST  = SND_W'(`X68K_DIV_SND - 1);
	localparam logic [SND2_W-1:0] SND2_LAST = SND2_W'(`X68K_DIV_SND_SLOW - 1);
	localparam logic [OPM_W-1:0]  OPM_LAST  = OPM_W'(`X68K_DIV_OPM - 1);

	logic [SYS_W-1:0]  div_sys;
	logic [SND_W-1:0]  div_snd;
	logic [SND2_W-1:0] div_snd2;
	logic [OPM_W-1:0]  div_opm;

	// CPU speed, only changes on a system enable
	logic turbo;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_sys  <= '0;
			div_snd  <= '0;
			div_snd2 <= '0;
			div_opm  <= '0;
			turbo    <= 1'b0;
			ce       <= '0;
		end else if (!ce_run) begin
			// Core in reset, everything parked at zero
			div_sys  <= '0;
			div_snd  <= '0;
			div_snd2 <= '0;
			div_opm  <= '0;
			turbo    <= 1'b0;
			ce       <= '0;
		end else begin
			////////////////////////////////////////
			// Modulo counters, each with its own wrap
			////////////////////////////////////////
			div_sys  <= (div_sys == SYS_LAST) ? '0 : div_sys + 1'b1;
			div_snd  <= (div_snd == SND_LAST) ? '0 : div_snd + 1'b1;
			div_snd2 <= (div_snd2 == SND2_LAST) ? '0 : div_snd2 + 1'b1;
			div_opm  <= (div_opm == OPM_LAST) ? '0 : div_opm + 1'b1;

			if (ce.sys_ce)
				turbo <= turbo_req;

			ce.sys_ce <= (div_sys == SYS_LAST);
			// Normal: cep with sys_ce, cen half a period later
			// Turbo: cep and cen alternate every clock
			ce.mpu_cep <= turbo ? div_sys[0] : (div_sys == SYS_LAST);
			ce.mpu_cen <= turbo ? ~div_sys[0] : (div_sys == SYS_W'(1));

			ce.snd_ce    <= snd_slow ? (div_snd2 == SND2_LAST) : (div_snd == SND_LAST);
			ce.opm_ce[0] <= (div_snd2 == SND2_LAST);
			ce.opm_ce[1] <= (div_opm == OPM_LAST);
		end
	end

endmodule

/* source/core_ctrl.sv */
// Core control block for reset sequencing and the loader write handshake
`timescale 1ns/1ps

module core_ctrl (
	input  logic                    clk_sys,
	input  logic                    arst_n,
	input  logic                    user_btn,
	input  logic                    menu_reset,
	input  logic                    host_reset,
	input  logic                    ioctl_download,
	input  logic                    ioctl_wr,
	input  logic                    ldr_ack,
	output logic                    sys_rstn,
	output logic                    ce_run,
	output logic                    ioctl_wait,
	output x68k_glue_pkg::ldr_bus_t ldr
);
	import x68k_glue_pkg::*;

	// Previous values for edge detection
	logic menu_q;
	logic dl_q;
	logic ack_q;

	// Sticky conditions for leaving reset
	logic dl_seen;
	logic menu_seen;

	// Any reset source, one cycle old
	logic rst_req;

	ldr_state_e state;

	logic dl_rise;
	logic dl_fall;
	logic menu_fall;
	logic ack_rise;

	assign dl_rise   = ioctl_download & ~dl_q;
	assign dl_fall   = ~ioctl_download & dl_q;
	assign menu_fall = ~menu_reset & menu_q;
	assign ack_rise  = ldr_ack & ~ack_q;

	////////////////////////////////////////
	// Reset sequencing
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			menu_q    <= 1'b0;
			dl_q      <= 1'b0;
			ack_q     <= 1'b0;
			dl_seen   <= 1'b0;
			menu_seen <= 1'b0;
			rst_req   <= 1'b0;
			sys_rstn  <= 1'b0;
		end else begin
			menu_q <= menu_reset;
			dl_q   <= ioctl_download;
			ack_q  <= ldr_ack;
			// Core stays in reset until the first ROM arrives
			if (dl_rise)
				dl_seen <= 1'b1;
			// Menu pulses reset once at startup
			if (menu_fall)
				menu_seen <= 1'b1;
			rst_req  <= user_btn | menu_reset | host_reset;
			// Second stage, so a button reaches sys_rstn in 2 cycles
			sys_rstn <= dl_seen & menu_seen & ~rst_req;
		end
	end

	// Enables only run while the core is out of reset
	assign ce_run = sys_rstn;

	////////////////////////////////////////
	// Loader FSM
	////////////////////////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= LDR_WAIT_DL;
		end else begin
			case (state)
				LDR_WAIT_DL: begin
					if (dl_rise)
						state <= LDR_IDLE;
				end
				LDR_IDLE: begin
					// End of download wins over a late write
					if (dl_fall)
						state <= LDR_DONE;
					else if (ioctl_wr)
						state <= LDR_WRITE;
				end
				LDR_WRITE: begin
					// Host is stalled here, further writes are dropped
					if (ack_rise)
						state <= ioctl_download ? LDR_IDLE : LDR_DONE;
				end
				default: begin
					// Done is final until the next arst_n
					state <= LDR_DONE;
				end
			endcase
		end
	end

	assign ldr.aen  = (state == LDR_IDLE) || (state == LDR_WRITE);
	assign ldr.wr   = (state == LDR_WRITE);
	assign ldr.done = (state == LDR_DONE);

	// Host waits for as long as a write is pending
	assign ioctl_wait = ldr.wr;

endmodule

/* source/x68k_glue_pkg.sv */
// X68000 glue shared types for enable bus, loader bus, MT32 status and video
package x68k_glue_pkg;

	////////////////////////////////////////
	// Buses
	////////////////////////////////////////

	// Clock enables toward the core, all single-cycle pulses
	typedef struct packed {
		logic       sys_ce;
		logic       mpu_cep;
		logic       mpu_cen;
		logic       snd_ce;
		// Bit 0 at 1/10, bit 1 at 1/20
		logic [1:0] opm_ce;
	} ce_bus_t;

	// Loader signals toward the core
	typedef struct packed {
		// Address enable while a download is active
		logic aen;
		// Write request, held until acknowledged
		logic wr;
		// Sticky, set once the first download ends
		logic done;
	} ldr_bus_t;

	// MT32-pi status as reported by the synth
	typedef struct packed {
		logic [7:0] mode;
		logic [1:0] rom;
		logic [2:0] sf;
	} mt32_stat_t;

	// One 24-bit pixel
	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	////////////////////////////////////////
	// State and selector encodings
	////////////////////////////////////////

	// Loader FSM
	typedef enum logic [1:0] {
		LDR_WAIT_DL,
		LDR_IDLE,
		LDR_WRITE,
		LDR_DONE
	} ldr_state_e;

	// Show Info menu option
	typedef enum logic [1:0] {
		INFO_OFF,
		INFO_ON_CHANGE,
		INFO_LCD_ON,
		INFO_LCD_AUTO
	} info_sel_e;

endpackage

/* source/x68k_glue_defs.svh */
// X68000 glue constants for clock dividers, MT32 mode decoding and hold times
`ifndef X68K_GLUE_DEFS_SVH
`define X68K_GLUE_DEFS_SVH

////////////////////////////////////////
// Clock-enable dividers
////////////////////////////////////////

// System enable, one pulse per 4 clocks
`define X68K_DIV_SYS 4

// Sound enable in normal clock mode
`define X68K_DIV_SND 5

// Sound enable in slow clock mode, also OPM enable 0
`define X68K_DIV_SND_SLOW 10

// OPM enable 1
`define X68K_DIV_OPM 20

////////////////////////////////////////
// MT32-pi mode bytes and info codes
////////////////////////////////////////

`define X68K_MT32_MODE_FLUID 8'hA2
`define X68K_MT32_MODE_MUNT 8'hA1

// Info menu entries, SoundFonts first, then ROMs
`define X68K_INFO_SF_BASE 4'd1
`define X68K_INFO_ROM_BASE 4'd9
`define X68K_INFO_UNKNOWN 4'd12

////////////////////////////////////////
// Hold times in clk_sys cycles
////////////////////////////////////////

`define X68K_LED_HOLD 4500000
`define X68K_LCD_HOLD 180000000

`endif
